//--- bench/membuf_tb.sv
// testbench for membuf_top with 2 lanes, 8 slots, 2 multipliers, 2 retire ports
// multiplier pool is behavioral with random latency, the LSU answers in order
// stimulus comes from an LFSR with a fixed seed, memory window is 8 words

`timescale 1ns/1ps

module membuf_tb;

	import membuf_pkg::*;

	localparam int EXEC_LEN    = 2;
	localparam int MMBUF_LEN   = 8;
	localparam int MUL_LEN     = 2;
	localparam int MEM_LEN     = 2;
	localparam int RLS_W       = $clog2(MEM_LEN+1);
	localparam int RUN_CYCLES  = 360;
	localparam int DRAIN_LIMIT = 2000;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                         clk = 1'b0;
	logic                         reset;
	logic [EXEC_LEN-1:0]          disp_valid;
	membuf_entry_t [EXEC_LEN-1:0] disp_entry;
	logic [RLS_W-1:0]             credit_return;
	logic                         lsu_req_valid;
	lsu_req_t                     lsu_req;
	logic                         lsu_ready;
	logic                         lsu_finished;
	xlen_t                        lsu_rdata;
	logic                         lsu_ack;
	logic [MUL_LEN-1:0]           mul_ready;
	logic [MUL_LEN-1:0]           mul_start;
	mul_req_t                     mul_req;
	logic [MUL_LEN-1:0]           mul_finished;
	xlen_t [MUL_LEN-1:0]          mul_data;
	logic [MUL_LEN-1:0]           mul_ack;
	logic [MEM_LEN-1:0]           wb_valid;
	wb_t [MEM_LEN-1:0]            wb;

	// model and scoreboard state
	logic [31:0]        lfsr = 32'h97a1_71c8;
	xlen_t              ref_mem [8];
	xlen_t              lsu_mem [8];
	xlen_t              lsu_results [$];
	wb_t                expected_q [$];
	logic [MUL_LEN-1:0] unit_busy;
	int                 unit_wait [MUL_LEN];
	int                 credits;
	int                 sent_total;
	int                 credit_total;
	int                 stall_cycles;

	// handshakes seen in the last cycle
	logic [MUL_LEN-1:0] seen_start;
	logic [MUL_LEN-1:0] seen_mul_ack;
	mul_req_t           seen_mul_req;
	logic               seen_lsu_acc;
	logic               seen_lsu_ack;
	lsu_req_t           seen_lsu_req;
	logic [RLS_W-1:0]   seen_credit;

	membuf_top #(
		.EXEC_LEN(EXEC_LEN), .MMBUF_LEN(MMBUF_LEN), .MUL_LEN(MUL_LEN), .MEM_LEN(MEM_LEN)
	) membuf_top_inst (.*);

	always #5 clk = ~clk;

	// ----------------------------------------
	// random source and reference
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// initial contents, every index gets its own word
	function automatic xlen_t mem_fill(input int idx);
		return 32'h3c00_0000 ^ (32'(idx) * 32'h0101_0101);
	endfunction

	// expected writeback, called in program order so ref_mem tracks older stores
	function automatic wb_t expect_wb(input membuf_entry_t e);
		wb_t         r;
		logic [63:0] prod;
		r.rd = e.rd;
		r.data = '0;
		if (e.kind == kind_mul) begin
			prod = 64'(e.opa) * 64'(e.opb);
			r.data = (e.op == OP_MULHU) ? prod[63:32] : prod[31:0];
		end else if (e.op == OP_STORE) begin
			r.rd = '0;
			ref_mem[e.opa[4:2]] = e.opb;
		end else begin
			r.data = ref_mem[e.opa[4:2]];
		end
		return r;
	endfunction

	// phase 1 leans to multiplies, phase 2 to loads and stores
	function automatic membuf_entry_t new_entry(input int phase);
		membuf_entry_t e;
		logic [1:0]    pick;
		logic [2:0]    idx;
		pick = 2'(rand_bits(2));
		case (phase)
			1: e.kind = (pick != 2'd0) ? kind_mul : kind_lsu;
			2: e.kind = (pick == 2'd0) ? kind_mul : kind_lsu;
			default: e.kind = pick[0] ? kind_mul : kind_lsu;
		endcase
		e.rd = rd_t'(rand_bits(5));
		if (e.kind == kind_mul) begin
			e.op = (rand_bits(1) != 0) ? OP_MULHU : OP_MUL;
			e.opa = rand_bits(32);
		end else begin
			e.op = (rand_bits(1) != 0) ? OP_STORE : OP_LOAD;
			idx = 3'(rand_bits(3));
			e.opa = {27'd0, idx, 2'b00};
		end
		e.opb = rand_bits(32);
		return e;
	endfunction

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_wb(input int lane, input wb_t got, input wb_t exp);
		if (got !== exp) begin
			fail_now($sformatf("MISMATCH wb[%0d] rd %h data %h, expected rd %h data %h",
				lane, got.rd, got.data, exp.rd, exp.data));
		end
	endtask

	task automatic check_count(input string name, input logic [RLS_W-1:0] got,
			input logic [RLS_W-1:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_zero(input string name, input logic [7:0] got);
		if (got !== 8'h00) begin
			fail_now($sformatf("MISMATCH %s got %h expected 00", name, got));
		end
	endtask

	task automatic check_idle();
		check_zero("wb_valid", 8'(wb_valid));
		check_zero("mul_start", 8'(mul_start));
		check_zero("mul_ack", 8'(mul_ack));
		check_zero("lsu_req_valid", 8'(lsu_req_valid));
		check_zero("lsu_ack", 8'(lsu_ack));
		check_count("credit_return", credit_return, '0);
	endtask

	// writebacks against the scoreboard, in dispatch order
	always @(negedge clk) begin : compare
		if (!reset) begin
			check_count("credit_return", credit_return, RLS_W'($countones(wb_valid)));
			for (int i = 0; i < MEM_LEN; i++) begin
				if (wb_valid[i]) begin
					if (i > 0 && !wb_valid[i-1]) begin
						fail_now("writeback valid bits are not contiguous from bit 0");
					end else if (expected_q.size() == 0) begin
						fail_now("writeback seen with no entry outstanding");
					end else begin
						check_wb(i, wb[i], expected_q.pop_front());
					end
				end
			end
			credit_total += int'(credit_return);
		end
	end

	// ----------------------------------------
	// unit models and dispatch
	// ----------------------------------------
	task automatic sample_handshakes();
		seen_start   = mul_start;
		seen_mul_ack = mul_ack;
		seen_mul_req = mul_req;
		seen_lsu_acc = lsu_req_valid && lsu_ready;
		seen_lsu_ack = lsu_ack;
		seen_lsu_req = lsu_req;
		seen_credit  = credit_return;
	endtask

	task automatic update_models(input int cyc, input int phase);
		logic [63:0] full;
		for (int u = 0; u < MUL_LEN; u++) begin
			if (seen_mul_ack[u]) begin
				unit_busy[u] = 1'b0;
				mul_finished[u] = 1'b0;
			end
			if (seen_start[u]) begin
				unit_busy[u] = 1'b1;
				full = {32'd0, seen_mul_req.rs0} * {32'd0, seen_mul_req.rs1};
				mul_data[u] = (seen_mul_req.op == OP_MULHU) ? full[63:32] : full[31:0];
				// long latency in the back-pressure phase
				if (phase == 3) begin
					unit_wait[u] = 16 + int'(rand_bits(5));
				end else begin
					unit_wait[u] = 1 + int'(rand_bits(3));
				end
			end else if (unit_busy[u] && !mul_finished[u]) begin
				if (unit_wait[u] == 0) begin
					mul_finished[u] = 1'b1;
				end else begin
					unit_wait[u]--;
				end
			end
		end
		mul_ready = ~unit_busy;

		if (seen_lsu_ack) begin
			void'(lsu_results.pop_front());
		end
		if (seen_lsu_acc) begin
			if (seen_lsu_req.op == OP_STORE) begin
				lsu_mem[seen_lsu_req.addr[4:2]] = seen_lsu_req.wdata;
				lsu_results.push_back('0);
			end else begin
				lsu_results.push_back(lsu_mem[seen_lsu_req.addr[4:2]]);
			end
		end
		lsu_finished = (lsu_results.size() != 0);
		lsu_rdata = lsu_finished ? lsu_results[0] : '0;
		if (phase == 3) begin
			lsu_ready = (cyc % 40) >= 20;
		end else if (phase >= 4) begin
			lsu_ready = 1'b1;
		end else begin
			lsu_ready = (rand_bits(3) != 0);
		end
	endtask

	// upstream side of the credit loop
	task automatic dispatch(input int cyc, input int phase);
		logic [EXEC_LEN-1:0] want;
		int                  used;
		credits += int'(seen_credit);
		disp_valid = '0;
		disp_entry = '0;
		used = 0;
		if (phase == 3) begin
			want = '1;
		end else if (phase >= 4) begin
			want = '0;
		end else if (phase == 0 && (cyc % 4) == 0) begin
			want = EXEC_LEN'(2);
		end else begin
			want = EXEC_LEN'(rand_bits(EXEC_LEN));
		end
		if (want != '0 && credits == 0) begin
			stall_cycles++;
		end
		for (int i = 0; i < EXEC_LEN; i++) begin
			if (want[i] && used < credits) begin
				disp_valid[i] = 1'b1;
				disp_entry[i] = new_entry(phase);
				expected_q.push_back(expect_wb(disp_entry[i]));
				used++;
			end
		end
		credits -= used;
		sent_total += used;
	endtask

	task automatic cycle_step(input int cyc, input int phase);
		@(posedge clk);
		#1;
		update_models(cyc, phase);
		dispatch(cyc, phase);
		@(negedge clk);
		#1;
		sample_handshakes();
	endtask

	// ----------------------------------------
	// sequence
	// ----------------------------------------
	initial begin : main
		int waited;
		reset = 1'b1;
		disp_valid = '0;
		disp_entry = '0;
		lsu_ready = 1'b0;
		lsu_finished = 1'b0;
		lsu_rdata = '0;
		mul_ready = '1;
		mul_finished = '0;
		mul_data = '0;
		unit_busy = '0;
		credits = MMBUF_LEN;
		sent_total = 0;
		credit_total = 0;
		stall_cycles = 0;
		for (int i = 0; i < 8; i++) begin
			ref_mem[i] = mem_fill(i);
			lsu_mem[i] = mem_fill(i);
		end

		// four reset cycles, outputs idle throughout
		@(posedge clk);
		repeat (3) begin
			@(negedge clk);
			check_idle();
			@(posedge clk);
		end
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_idle();
		#1;
		sample_handshakes();

		// sparse lanes, multiplies, loads/stores, then back-pressure
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			cycle_step(cyc, cyc / 90);
		end

		waited = 0;
		while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
			cycle_step(waited, 4);
			waited++;
		end

		if (expected_q.size() != 0) begin
			fail_now("timeout while waiting for the last writebacks");
		end else if (stall_cycles == 0) begin
			fail_now("dispatch never ran out of credits");
		end else if (credit_total != sent_total) begin
			fail_now($sformatf("MISMATCH credit_return total %h expected %h",
				credit_total, sent_total));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- hw/entry_compact.sv
// squeezes the empty dispatch lanes out, lane order is kept
// purely combinational, no flow control of its own

`timescale 1ns/1ps

module entry_compact #(
	parameter int EXEC_LEN = 2
) (
	input  logic [EXEC_LEN-1:0]                         disp_valid,
	input  membuf_pkg::membuf_entry_t [EXEC_LEN-1:0]    disp_entry,
	output membuf_pkg::membuf_entry_t [EXEC_LEN-1:0]    dense_entry,
	output logic [$clog2(EXEC_LEN+1)-1:0]               dense_count
);

	localparam int CNT_W = $clog2(EXEC_LEN+1);

	// ----------------------------------------
	// prefix count gives each lane its place
	// ----------------------------------------
	always_comb begin : compact
		logic [CNT_W-1:0] pos;

		pos = '0;
		dense_entry = '0;
		for (int i = 0; i < EXEC_LEN; i++) begin
			if (disp_valid[i]) begin
				// lanes above the valid count stay zero
				dense_entry[pos] = disp_entry[i];
				pos = pos + 1'b1;
			end
		end
		dense_count = pos;
	end

endmodule

//--- hw/entry_queue.sv
// ordered entry store where slot 0 always holds the oldest entry
// release and append share one edge and appends land at occupancy minus release
// upstream must hold a credit for every lane it sends and nothing is refused

`timescale 1ns/1ps

module entry_queue #(
	parameter int EXEC_LEN  = 2,
	parameter int MMBUF_LEN = 8,
	parameter int MEM_LEN   = 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  membuf_pkg::membuf_entry_t [EXEC_LEN-1:0]    dense_entry,
	input  logic [$clog2(EXEC_LEN+1)-1:0]               dense_count,
	input  logic [$clog2(MEM_LEN+1)-1:0]                release_count,
	output membuf_pkg::membuf_entry_t [MMBUF_LEN-1:0]   slot,
	output logic [$clog2(MMBUF_LEN+1)-1:0]              occupancy
);

	import membuf_pkg::*;

	localparam int OCC_W = $clog2(MMBUF_LEN+1);

	membuf_entry_t [MMBUF_LEN-1:0] slot_next;
	logic [OCC_W-1:0]              kept;

	// entries that survive the release this cycle
	assign kept = occupancy - OCC_W'(release_count);

	// ----------------------------------------
	// shift out retired entries and append
	// ----------------------------------------
	always_comb begin : next_slots
		int src;
		int dst;

		for (int i = 0; i < MMBUF_LEN; i++) begin
			src = i + int'(release_count);
			if (src < MMBUF_LEN) begin
				slot_next[i] = slot[src];
			end else begin
				slot_next[i] = '0;
			end
		end

		for (int j = 0; j < EXEC_LEN; j++) begin
			dst = int'(kept) + j;
			if (j < int'(dense_count) && dst < MMBUF_LEN) begin
				slot_next[dst] = dense_entry[j];
			end
		end
	end

	// slot contents shift and fill on every edge
	always_ff @(posedge clk) begin
		slot <= slot_next;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			occupancy <= kept + OCC_W'(dense_count);
		end
	end

	// credit flow upstream must keep the queue from overflowing
	a_no_overflow : assert property (
		@(posedge clk) disable iff (reset)
		(int'(occupancy) + int'(dense_count)) <= MMBUF_LEN
	);

endmodule

//--- hw/lsu_issue.sv
// in-order load/store issue to the single LSU port
// the pointer jumps over multiply entries to the next load/store
// pointer follows the queue shift and never drops below zero

`timescale 1ns/1ps

module lsu_issue #(
	parameter int MMBUF_LEN = 8,
	parameter int MEM_LEN   = 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  membuf_pkg::membuf_entry_t [MMBUF_LEN-1:0]   slot,
	input  logic [$clog2(MMBUF_LEN+1)-1:0]              occupancy,
	input  logic [$clog2(MEM_LEN+1)-1:0]                release_count,
	input  logic                                        lsu_ready,
	output logic                                        lsu_req_valid,
	output membuf_pkg::lsu_req_t                        lsu_req,
	output logic                                        lsu_issue_valid,
	output logic [(MMBUF_LEN > 1 ? $clog2(MMBUF_LEN) : 1)-1:0] lsu_issue_slot
);

	import membuf_pkg::*;

	localparam int SLOT_W = (MMBUF_LEN > 1) ? $clog2(MMBUF_LEN) : 1;
	localparam int OCC_W  = $clog2(MMBUF_LEN+1);

	logic [OCC_W-1:0]  ptr;
	logic [OCC_W-1:0]  ptr_next;
	logic              found;
	logic [SLOT_W-1:0] cand;

	// first load/store at or past the pointer
	always_comb begin : search
		found = 1'b0;
		cand = '0;
		for (int i = 0; i < MMBUF_LEN; i++) begin
			if (!found && i >= int'(ptr) && i < int'(occupancy) && slot[i].kind == kind_lsu) begin
				found = 1'b1;
				cand = SLOT_W'(i);
			end
		end
	end

	assign lsu_req_valid   = found;
	assign lsu_req.op      = slot[cand].op;
	assign lsu_req.addr    = slot[cand].opa;
	assign lsu_req.wdata   = slot[cand].opb;
	assign lsu_issue_valid = found & lsu_ready;
	assign lsu_issue_slot  = cand;

	always_comb begin : advance
		logic [OCC_W-1:0] moved;

		if (!found) begin
			moved = occupancy;
		end else if (lsu_ready) begin
			moved = OCC_W'(cand) + 1'b1;
		end else begin
			moved = OCC_W'(cand);
		end
		// retired multiplies ahead of the pointer pull it to zero
		ptr_next = (moved < OCC_W'(release_count)) ? '0 : moved - OCC_W'(release_count);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else begin
			ptr <= ptr_next;
		end
	end

endmodule

//--- hw/membuf_pkg.sv
// shared types for the memory and multiply reorder buffer
// op codes are private to this buffer; the dispatch stage must map onto them
// a store or an entry with rd zero writes no register

package membuf_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      rd_t;
	typedef logic [2:0]      mem_op_t;

	// ----------------------------------------
	// operation codes
	// ----------------------------------------
	// multiply entries
	localparam mem_op_t OP_MUL   = 3'd0;
	localparam mem_op_t OP_MULHU = 3'd3;
	// load/store entries
	localparam mem_op_t OP_LOAD  = 3'd0;
	localparam mem_op_t OP_STORE = 3'd1;

	typedef enum logic {
		kind_lsu,
		kind_mul
	} entry_kind_e;

	// one queue slot, opa is address or rs0, opb is store data or rs1
	typedef struct packed {
		entry_kind_e kind;
		mem_op_t     op;
		rd_t         rd;
		xlen_t       opa;
		xlen_t       opb;
	} membuf_entry_t;

	typedef struct packed {
		mem_op_t op;
		xlen_t   addr;
		xlen_t   wdata;
	} lsu_req_t;

	typedef struct packed {
		mem_op_t op;
		xlen_t   rs0;
		xlen_t   rs1;
	} mul_req_t;

	typedef struct packed {
		rd_t   rd;
		xlen_t data;
	} wb_t;

endpackage

//--- hw/membuf_top.sv
// memory and multiply reorder buffer
// dispatch uses credits: MMBUF_LEN after reset, credit_return adds back
// assumes MEM_LEN <= MMBUF_LEN and EXEC_LEN <= MMBUF_LEN

`timescale 1ns/1ps

module membuf_top #(
	parameter int EXEC_LEN  = 2,
	parameter int MMBUF_LEN = 8,
	parameter int MUL_LEN   = 2,
	parameter int MEM_LEN   = 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	// dispatch
	input  logic [EXEC_LEN-1:0]                         disp_valid,
	input  membuf_pkg::membuf_entry_t [EXEC_LEN-1:0]    disp_entry,
	output logic [$clog2(MEM_LEN+1)-1:0]                credit_return,
	// lsu
	output logic                                        lsu_req_valid,
	output membuf_pkg::lsu_req_t                        lsu_req,
	input  logic                                        lsu_ready,
	input  logic                                        lsu_finished,
	input  membuf_pkg::xlen_t                           lsu_rdata,
	output logic                                        lsu_ack,
	// multipliers
	input  logic [MUL_LEN-1:0]                          mul_ready,
	output logic [MUL_LEN-1:0]                          mul_start,
	output membuf_pkg::mul_req_t                        mul_req,
	input  logic [MUL_LEN-1:0]                          mul_finished,
	input  membuf_pkg::xlen_t [MUL_LEN-1:0]             mul_data,
	output logic [MUL_LEN-1:0]                          mul_ack,
	// writeback
	output logic [MEM_LEN-1:0]                          wb_valid,
	output membuf_pkg::wb_t [MEM_LEN-1:0]               wb
);

	import membuf_pkg::*;

	localparam int CNT_W  = $clog2(EXEC_LEN+1);
	localparam int RLS_W  = $clog2(MEM_LEN+1);
	localparam int OCC_W  = $clog2(MMBUF_LEN+1);
	localparam int SLOT_W = (MMBUF_LEN > 1) ? $clog2(MMBUF_LEN) : 1;
	localparam int UNIT_W = (MUL_LEN > 1) ? $clog2(MUL_LEN) : 1;

	membuf_entry_t [EXEC_LEN-1:0]  dense_entry;
	logic [CNT_W-1:0]              dense_count;
	membuf_entry_t [MMBUF_LEN-1:0] slot;
	logic [OCC_W-1:0]              occupancy;
	logic [RLS_W-1:0]              release_count;
	logic                          mul_issue_valid;
	logic [SLOT_W-1:0]             mul_issue_slot;
	logic [UNIT_W-1:0]             mul_issue_unit;
	logic                          lsu_issue_valid;
	logic [SLOT_W-1:0]             lsu_issue_slot;

	// every retired entry frees one queue slot
	assign credit_return = release_count;

	entry_compact #(.EXEC_LEN(EXEC_LEN)) entry_compact_inst (.*);

	entry_queue #(
		.EXEC_LEN(EXEC_LEN), .MMBUF_LEN(MMBUF_LEN), .MEM_LEN(MEM_LEN)
	) entry_queue_inst (.*);

	mul_issue #(
		.MMBUF_LEN(MMBUF_LEN), .MUL_LEN(MUL_LEN), .MEM_LEN(MEM_LEN)
	) mul_issue_inst (.*);

	lsu_issue #(.MMBUF_LEN(MMBUF_LEN), .MEM_LEN(MEM_LEN)) lsu_issue_inst (.*);

	retire_unit #(
		.MMBUF_LEN(MMBUF_LEN), .MUL_LEN(MUL_LEN), .MEM_LEN(MEM_LEN)
	) retire_unit_inst (.*);

endmodule

//--- hw/mul_issue.sv
// out-of-order multiply issue to a pool of units
// oldest unissued multiply goes to the lowest ready unit at one issue per cycle
// a unit that was started keeps mul_ready low until its result is acked

`timescale 1ns/1ps

module mul_issue #(
	parameter int MMBUF_LEN = 8,
	parameter int MUL_LEN   = 2,
	parameter int MEM_LEN   = 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  membuf_pkg::membuf_entry_t [MMBUF_LEN-1:0]   slot,
	input  logic [$clog2(MMBUF_LEN+1)-1:0]              occupancy,
	input  logic [$clog2(MEM_LEN+1)-1:0]                release_count,
	input  logic [MUL_LEN-1:0]                          mul_ready,
	output logic [MUL_LEN-1:0]                          mul_start,
	output membuf_pkg::mul_req_t                        mul_req,
	output logic                                        mul_issue_valid,
	output logic [(MMBUF_LEN > 1 ? $clog2(MMBUF_LEN) : 1)-1:0] mul_issue_slot,
	output logic [(MUL_LEN > 1 ? $clog2(MUL_LEN) : 1)-1:0]     mul_issue_unit
);

	import membuf_pkg::*;

	localparam int SLOT_W = (MMBUF_LEN > 1) ? $clog2(MMBUF_LEN) : 1;
	localparam int UNIT_W = (MUL_LEN > 1) ? $clog2(MUL_LEN) : 1;

	logic [MMBUF_LEN-1:0] issued;
	logic                 slot_found;
	logic [SLOT_W-1:0]    pick_slot;
	logic                 unit_found;
	logic [UNIT_W-1:0]    pick_unit;

	// ----------------------------------------
	// oldest waiting multiply
	// ----------------------------------------
	always_comb begin : pick_entry
		slot_found = 1'b0;
		pick_slot = '0;
		for (int i = 0; i < MMBUF_LEN; i++) begin
			if (!slot_found && i < int'(occupancy) && slot[i].kind == kind_mul && !issued[i]) begin
				slot_found = 1'b1;
				pick_slot = SLOT_W'(i);
			end
		end
	end

	// lowest idle unit
	always_comb begin : pick_idle
		unit_found = 1'b0;
		pick_unit = '0;
		for (int u = 0; u < MUL_LEN; u++) begin
			if (!unit_found && mul_ready[u]) begin
				unit_found = 1'b1;
				pick_unit = UNIT_W'(u);
			end
		end
	end

	assign mul_issue_valid = slot_found & unit_found;
	assign mul_issue_slot  = pick_slot;
	assign mul_issue_unit  = pick_unit;
	assign mul_start       = mul_issue_valid ? (MUL_LEN'(1) << pick_unit) : '0;

	assign mul_req.op  = slot[pick_slot].op;
	assign mul_req.rs0 = slot[pick_slot].opa;
	assign mul_req.rs1 = slot[pick_slot].opb;

	// issued marks follow the queue shift
	always_ff @(posedge clk) begin
		if (reset) begin
			issued <= '0;
		end else if (mul_issue_valid) begin
			issued <= (issued | (MMBUF_LEN'(1) << pick_slot)) >> release_count;
		end else begin
			issued <= issued >> release_count;
		end
	end

	// a started unit must not look idle in the next cycle
	a_started_unit_busy : assert property (
		@(posedge clk) disable iff (reset)
		(mul_start != '0) |=> ((mul_ready & $past(mul_start)) == '0)
	);

endmodule

//--- hw/retire_unit.sv
// in-order retirement of up to MEM_LEN finished entries per cycle
// at most one LSU result per cycle and LSU results arrive in request order
// stores retire with rd and data forced to zero

`timescale 1ns/1ps

module retire_unit #(
	parameter int MMBUF_LEN = 8,
	parameter int MUL_LEN   = 2,
	parameter int MEM_LEN   = 2
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  membuf_pkg::membuf_entry_t [MMBUF_LEN-1:0]   slot,
	input  logic                                        mul_issue_valid,
	input  logic [(MMBUF_LEN > 1 ? $clog2(MMBUF_LEN) : 1)-1:0] mul_issue_slot,
	input  logic [(MUL_LEN > 1 ? $clog2(MUL_LEN) : 1)-1:0]     mul_issue_unit,
	input  logic                                        lsu_issue_valid,
	input  logic [(MMBUF_LEN > 1 ? $clog2(MMBUF_LEN) : 1)-1:0] lsu_issue_slot,
	input  logic [MUL_LEN-1:0]                          mul_finished,
	input  membuf_pkg::xlen_t [MUL_LEN-1:0]             mul_data,
	input  logic                                        lsu_finished,
	input  membuf_pkg::xlen_t                           lsu_rdata,
	output logic [MUL_LEN-1:0]                          mul_ack,
	output logic                                        lsu_ack,
	output logic [$clog2(MEM_LEN+1)-1:0]                release_count,
	output logic [MEM_LEN-1:0]                          wb_valid,
	output membuf_pkg::wb_t [MEM_LEN-1:0]               wb
);

	import membuf_pkg::*;

	localparam int UNIT_W = (MUL_LEN > 1) ? $clog2(MUL_LEN) : 1;

	// done marks a slot handed to a unit
	logic [MMBUF_LEN-1:0] done;
	logic [MMBUF_LEN-1:0] is_mul;
	logic [UNIT_W-1:0]    unit_of [MMBUF_LEN];
	logic [MMBUF_LEN-1:0] set_mul;
	logic [MMBUF_LEN-1:0] set_lsu;

	assign set_mul = mul_issue_valid ? (MMBUF_LEN'(1) << mul_issue_slot) : '0;
	assign set_lsu = lsu_issue_valid ? (MMBUF_LEN'(1) << lsu_issue_slot) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			done   <= '0;
			is_mul <= '0;
		end else begin
			done   <= (done | set_mul | set_lsu) >> release_count;
			is_mul <= (is_mul | set_mul) >> release_count;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < MMBUF_LEN; i++) begin
			if (i + int'(release_count) < MMBUF_LEN) begin
				if (set_mul[i + int'(release_count)]) begin
					unit_of[i] <= mul_issue_unit;
				end else begin
					unit_of[i] <= unit_of[i + int'(release_count)];
				end
			end
		end
	end

	// ----------------------------------------
	// retire chain over the oldest slots
	// ----------------------------------------
	always_comb begin : chain
		logic [MUL_LEN-1:0] mul_left;
		logic               lsu_left;
		logic               blocked;
		logic               ok;
		logic               store;
		logic [UNIT_W-1:0]  u;

		mul_left = mul_finished;
		lsu_left = lsu_finished;
		blocked = 1'b0;
		release_count = '0;
		wb_valid = '0;
		wb = '0;
		mul_ack = '0;
		lsu_ack = 1'b0;
		for (int i = 0; i < MEM_LEN; i++) begin
			u = unit_of[i];
			store = (slot[i].kind == kind_lsu) && (slot[i].op == OP_STORE);
			ok = is_mul[i] ? mul_left[u] : lsu_left;
			if (!blocked && done[i] && ok) begin
				wb_valid[i] = 1'b1;
				wb[i].rd = store ? '0 : slot[i].rd;
				if (is_mul[i]) begin
					wb[i].data = mul_data[u];
					mul_left[u] = 1'b0;
					mul_ack[u] = 1'b1;
				end else begin
					wb[i].data = store ? '0 : lsu_rdata;
					// only one LSU result per cycle
					lsu_left = 1'b0;
					lsu_ack = 1'b1;
				end
				release_count = release_count + 1'b1;
			end else begin
				blocked = 1'b1;
			end
		end
	end

	// a finished result stays until its ack
	a_lsu_result_held : assert property (
		@(posedge clk) disable iff (reset)
		(lsu_finished && !lsu_ack) |=> (lsu_finished && $stable(lsu_rdata))
	);

	a_mul_result_held : assert property (
		@(posedge clk) disable iff (reset)
		((mul_finished & ~mul_ack) != '0) |=>
			(($past(mul_finished & ~mul_ack) & ~mul_finished) == '0)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -sv -Wno-fatal --top-module membuf_tb \
	-Mdir obj_dir -o membuf_sim -f vlog.f ||
exit 1
sim_out="$(./obj_dir/membuf_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF "RESULT: PASS" && exit 0 || exit 1

//--- vlog.f
hw/membuf_pkg.sv
hw/entry_compact.sv
hw/entry_queue.sv
hw/mul_issue.sv
hw/lsu_issue.sv
hw/retire_unit.sv
hw/membuf_top.sv
bench/membuf_tb.sv
